/* logic/surf_phy_pkg.sv */
package surf_phy_pkg;

    // word widths per lane
    localparam int DOUT_BITS = 8;
    localparam int COUT_BITS = 4;

    // delay line reaches 0 to 31 bit times
    localparam int MAX_TAP = 31;

    // word buffer between the lanes and the register block
    localparam int FIFO_DEPTH = 8;

    // assembled dout word, msb is the oldest bit
    typedef logic [DOUT_BITS-1:0] dout_word_t;

    // assembled cout word, half the dout width
    typedef logic [COUT_BITS-1:0] cout_nib_t;

    // delay tap select
    typedef logic [4:0] tap_t;

    // fifo fill count, 0 to FIFO_DEPTH
    typedef logic [3:0] fill_t;

endpackage

/* logic/surf_apb_pkg.sv */
package surf_apb_pkg;

    // byte address and data of the register port
    typedef logic [4:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // register map
    localparam apb_addr_t REG_CTRL    = 5'h00;
    localparam apb_addr_t REG_TAP     = 5'h04;
    localparam apb_addr_t REG_TAP_CUR = 5'h08;
    localparam apb_addr_t REG_STATUS  = 5'h0C;
    localparam apb_addr_t REG_DATA    = 5'h10;

    // bits of REG_CTRL, each one a single cycle pulse
    localparam int CTRL_LOAD_COUT = 0;
    localparam int CTRL_LOAD_DOUT = 1;
    localparam int CTRL_SLIP_COUT = 2;
    localparam int CTRL_SLIP_DOUT = 3;

endpackage

/* logic/rx_ifs.sv */
// assembled words from a producer to a consumer
interface lane_word_if;
    logic                       valid;
    surf_phy_pkg::dout_word_t   dout;
    surf_phy_pkg::cout_nib_t    cout;
    logic                       ready;

    modport src (
        output valid,
        output dout,
        output cout,
        input  ready
    );

    modport dst (
        input  valid,
        input  dout,
        input  cout,
        output ready
    );
endinterface

// tap loads and bitslips from the register block, current taps back
interface phy_ctrl_if;
    surf_phy_pkg::tap_t tap_value;
    logic               load_cout;
    logic               load_dout;
    logic               slip_cout;
    logic               slip_dout;
    surf_phy_pkg::tap_t cout_tap;
    surf_phy_pkg::tap_t dout_tap;

    modport ctl (
        output tap_value,
        output load_cout,
        output load_dout,
        output slip_cout,
        output slip_dout,
        input  cout_tap,
        input  dout_tap
    );

    modport phy (
        input  tap_value,
        input  load_cout,
        input  load_dout,
        input  slip_cout,
        input  slip_dout,
        output cout_tap,
        output dout_tap
    );
endinterface

/* logic/lane_deserializer.sv */
module lane_deserializer #(
    parameter bit COUT_INV = 1'b0,
    parameter bit DOUT_INV = 1'b0
) (
    input  logic     sysclk_i,
    input  logic     iserdes_rst_i,
    input  logic     dout_sync_i,
    input  logic     cout_i,
    input  logic     dout_i,
    phy_ctrl_if.phy  ctrl_i,
    lane_word_if.src word_o
);

    typedef enum logic {
        HOLD,
        RUN
    } align_state_t;

    align_state_t state;

    // lane 0 is cout, lane 1 is dout
    logic [1:0]                      ser_in;
    logic [1:0]                      ser_dly;
    logic [1:0]                      tap_load;
    logic [surf_phy_pkg::MAX_TAP:0]  hist [2];
    surf_phy_pkg::tap_t              tap [2];

    logic [$clog2(surf_phy_pkg::DOUT_BITS)-1:0] bit_cnt;
    surf_phy_pkg::dout_word_t dout_sr;
    surf_phy_pkg::dout_word_t dout_next;
    surf_phy_pkg::cout_nib_t  cout_sr;
    surf_phy_pkg::cout_nib_t  cout_next;
    logic bit_adv;
    logic cout_step;
    logic cout_skip;
    logic skip_now;
    logic word_done;

    logic                     word_valid;
    surf_phy_pkg::dout_word_t word_dout;
    surf_phy_pkg::cout_nib_t  word_cout;

    // fixed polarity swap per lane
    assign ser_in   = {dout_i ^ DOUT_INV, cout_i ^ COUT_INV};
    assign tap_load = {ctrl_i.load_dout, ctrl_i.load_cout};

    // realignment hold, released only on a dout_sync_i edge
    always_ff @(posedge sysclk_i) begin
        if (iserdes_rst_i) begin
            state <= HOLD;
        end else if (state == HOLD && dout_sync_i) begin
            state <= RUN;
        end
    end

    // delay line, hist[k] holds the bit from k+1 cycles ago
    always_ff @(posedge sysclk_i) begin
        for (int l = 0; l < 2; l++) begin
            hist[l] <= {hist[l][surf_phy_pkg::MAX_TAP-1:0], ser_in[l]};
        end
    end

    always_ff @(posedge sysclk_i) begin
        for (int l = 0; l < 2; l++) begin
            if (iserdes_rst_i) begin
                tap[l] <= '0;
            end else if (tap_load[l]) begin
                tap[l] <= ctrl_i.tap_value;
            end
        end
    end

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            ser_dly[l] = hist[l][tap[l]];
        end
    end

    assign ctrl_i.cout_tap = tap[0];
    assign ctrl_i.dout_tap = tap[1];

    // a dout slip stalls the counter, which moves the word boundary by one bit
    assign bit_adv   = !ctrl_i.slip_dout;
    assign cout_step = bit_adv && bit_cnt[0];
    assign skip_now  = cout_skip || ctrl_i.slip_cout;
    assign word_done = bit_adv &&
                       (bit_cnt == $bits(bit_cnt)'(surf_phy_pkg::DOUT_BITS - 1));

    assign dout_next = {dout_sr[surf_phy_pkg::DOUT_BITS-2:0], ser_dly[1]};
    assign cout_next = (cout_step && !skip_now) ?
                       {cout_sr[surf_phy_pkg::COUT_BITS-2:0], ser_dly[0]} : cout_sr;

    always_ff @(posedge sysclk_i) begin
        if (iserdes_rst_i || state == HOLD) begin
            bit_cnt    <= '0;
            dout_sr    <= '0;
            cout_sr    <= '0;
            cout_skip  <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            dout_sr    <= dout_next;
            cout_sr    <= cout_next;
            word_valid <= word_done;
            if (bit_adv) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            // a pending cout slip is used up on the next shift slot
            cout_skip <= cout_step ? 1'b0 : skip_now;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (word_done) begin
            word_dout <= dout_next;
            word_cout <= cout_next;
        end
    end

    // ready is not looked at, the fifo drops what it cannot take
    assign word_o.valid = word_valid;
    assign word_o.dout  = word_dout;
    assign word_o.cout  = word_cout;

endmodule

/* logic/word_fifo.sv */
module word_fifo (
    input  logic                sysclk_i,
    input  logic                iserdes_rst_i,
    input  logic                ovf_clr_i,
    lane_word_if.dst            wr_i,
    lane_word_if.src            rd_o,
    output surf_phy_pkg::fill_t fill_o,
    output logic                ovf_o
);

    logic [$clog2(surf_phy_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(surf_phy_pkg::FIFO_DEPTH)-1:0] rd_ptr;

    surf_phy_pkg::dout_word_t mem_dout [surf_phy_pkg::FIFO_DEPTH];
    surf_phy_pkg::cout_nib_t  mem_cout [surf_phy_pkg::FIFO_DEPTH];

    surf_phy_pkg::fill_t fill;
    logic full;
    logic push;
    logic pop;
    logic ovf;

    assign full       = (fill == surf_phy_pkg::fill_t'(surf_phy_pkg::FIFO_DEPTH));
    assign wr_i.ready = !full;
    assign push       = wr_i.valid && wr_i.ready;
    assign rd_o.valid = (fill != '0);
    assign pop        = rd_o.valid && rd_o.ready;

    always_ff @(posedge sysclk_i) begin
        if (iserdes_rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
            ovf    <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            // sticky, a drop in the same cycle wins over the clear
            if (wr_i.valid && !wr_i.ready) begin
                ovf <= 1'b1;
            end else if (ovf_clr_i) begin
                ovf <= 1'b0;
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (push) begin
            mem_dout[wr_ptr] <= wr_i.dout;
            mem_cout[wr_ptr] <= wr_i.cout;
        end
    end

    assign rd_o.dout = mem_dout[rd_ptr];
    assign rd_o.cout = mem_cout[rd_ptr];
    assign fill_o    = fill;
    assign ovf_o     = ovf;

endmodule

/* logic/phy_ctrl_apb.sv */
module phy_ctrl_apb (
    input  logic                    sysclk_i,
    input  logic                    iserdes_rst_i,
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  surf_apb_pkg::apb_addr_t paddr_i,
    input  surf_apb_pkg::apb_data_t pwdata_i,
    input  surf_phy_pkg::fill_t     fill_i,
    input  logic                    ovf_i,
    output surf_apb_pkg::apb_data_t prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,
    output logic                    ovf_clr_o,
    phy_ctrl_if.ctl                 ctrl_o,
    lane_word_if.dst                word_i
);

    logic               access;
    logic               wr_access;
    logic               rd_access;
    logic               ctrl_wr;
    logic               addr_err;
    surf_phy_pkg::tap_t tap_reg;

    // no wait states, every access phase completes
    assign pready_o  = 1'b1;
    assign access    = psel_i && penable_i;
    assign wr_access = access && pwrite_i;
    assign rd_access = access && !pwrite_i;

    always_ff @(posedge sysclk_i) begin
        if (iserdes_rst_i) begin
            tap_reg <= '0;
        end else if (wr_access && paddr_i == surf_apb_pkg::REG_TAP) begin
            tap_reg <= pwdata_i[4:0];
        end
    end

    // pulses come straight out of the access phase so loads land on the next edge
    assign ctrl_wr          = wr_access && (paddr_i == surf_apb_pkg::REG_CTRL);
    assign ctrl_o.tap_value = tap_reg;
    assign ctrl_o.load_cout = ctrl_wr && pwdata_i[surf_apb_pkg::CTRL_LOAD_COUT];
    assign ctrl_o.load_dout = ctrl_wr && pwdata_i[surf_apb_pkg::CTRL_LOAD_DOUT];
    assign ctrl_o.slip_cout = ctrl_wr && pwdata_i[surf_apb_pkg::CTRL_SLIP_COUT];
    assign ctrl_o.slip_dout = ctrl_wr && pwdata_i[surf_apb_pkg::CTRL_SLIP_DOUT];

    // status bit 8 is write one to clear
    assign ovf_clr_o = wr_access && (paddr_i == surf_apb_pkg::REG_STATUS) && pwdata_i[8];

    // pop at the end of a data read, only when a word is there
    assign word_i.ready = rd_access && (paddr_i == surf_apb_pkg::REG_DATA) && word_i.valid;

    always_comb begin
        prdata_o = '0;
        addr_err = 1'b0;
        case (paddr_i)
            surf_apb_pkg::REG_CTRL: begin
                prdata_o = '0;
            end
            surf_apb_pkg::REG_TAP: begin
                prdata_o[4:0] = tap_reg;
            end
            surf_apb_pkg::REG_TAP_CUR: begin
                prdata_o[4:0]  = ctrl_o.cout_tap;
                prdata_o[12:8] = ctrl_o.dout_tap;
                addr_err       = pwrite_i;
            end
            surf_apb_pkg::REG_STATUS: begin
                prdata_o[3:0] = fill_i;
                prdata_o[8]   = ovf_i;
            end
            surf_apb_pkg::REG_DATA: begin
                // empty fifo reads as all zero
                if (word_i.valid) begin
                    prdata_o[7:0]  = word_i.dout;
                    prdata_o[11:8] = word_i.cout;
                    prdata_o[31]   = 1'b1;
                end
                addr_err = pwrite_i;
            end
            default: begin
                addr_err = 1'b1;
            end
        endcase
    end

    assign pslverr_o = access && addr_err;

endmodule

/* logic/surf_cout_rx.sv */
module surf_cout_rx #(
    parameter bit COUT_INV = 1'b0,
    parameter bit DOUT_INV = 1'b0
) (
    input  logic                    sysclk_i,
    input  logic                    iserdes_rst_i,
    input  logic                    dout_sync_i,
    input  logic                    cout_i,
    input  logic                    dout_i,
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  surf_apb_pkg::apb_addr_t paddr_i,
    input  surf_apb_pkg::apb_data_t pwdata_i,
    output surf_apb_pkg::apb_data_t prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o
);

    surf_phy_pkg::fill_t fill;
    logic                ovf;
    logic                ovf_clr;

    // deserializer to fifo, then fifo to register block
    lane_word_if phy_word ();
    lane_word_if fifo_word ();
    phy_ctrl_if  phy_ctrl ();

    lane_deserializer #(
        .COUT_INV(COUT_INV),
        .DOUT_INV(DOUT_INV)
    ) lane_deserializer_i (
        .sysclk_i     (sysclk_i),
        .iserdes_rst_i(iserdes_rst_i),
        .dout_sync_i  (dout_sync_i),
        .cout_i       (cout_i),
        .dout_i       (dout_i),
        .ctrl_i       (phy_ctrl),
        .word_o       (phy_word)
    );

    word_fifo word_fifo_i (
        .sysclk_i     (sysclk_i),
        .iserdes_rst_i(iserdes_rst_i),
        .ovf_clr_i    (ovf_clr),
        .wr_i         (phy_word),
        .rd_o         (fifo_word),
        .fill_o       (fill),
        .ovf_o        (ovf)
    );

    phy_ctrl_apb phy_ctrl_apb_i (
        .sysclk_i     (sysclk_i),
        .iserdes_rst_i(iserdes_rst_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .fill_i       (fill),
        .ovf_i        (ovf),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .ovf_clr_o    (ovf_clr),
        .ctrl_o       (phy_ctrl),
        .word_i       (fifo_word)
    );

endmodule

/* sim/surf_cout_rx_sva.sv */
module surf_cout_rx_sva (
    input logic                clk_i,
    input logic                rst_i,
    input surf_phy_pkg::fill_t fill_i,
    input logic                pop_i,
    input logic                psel_i,
    input logic                penable_i,
    input logic                pready_i
);

    fill_bound_a: assert property (@(posedge clk_i) disable iff (rst_i)
        fill_i <= surf_phy_pkg::fill_t'(surf_phy_pkg::FIFO_DEPTH))
        else $error("fifo fill above its depth");

    // a pop request from the register block needs at least one stored word
    pop_nonempty_a: assert property (@(posedge clk_i) disable iff (rst_i)
        pop_i |-> fill_i != '0)
        else $error("fifo popped while empty");

    pready_access_a: assert property (@(posedge clk_i) disable iff (rst_i)
        (psel_i && penable_i) |-> pready_i)
        else $error("access phase without pready");

endmodule

// fifo side, the apb inputs are tied idle
bind word_fifo surf_cout_rx_sva fifo_sva_i (
    .clk_i    (sysclk_i),
    .rst_i    (iserdes_rst_i),
    .fill_i   (fill),
    .pop_i    (rd_o.ready),
    .psel_i   (1'b0),
    .penable_i(1'b0),
    .pready_i (1'b1)
);

bind phy_ctrl_apb surf_cout_rx_sva apb_sva_i (
    .clk_i    (sysclk_i),
    .rst_i    (iserdes_rst_i),
    .fill_i   (fill_i),
    .pop_i    (word_i.ready),
    .psel_i   (psel_i),
    .penable_i(penable_i),
    .pready_i (pready_o)
);

/* sim/surf_cout_rx_tb.sv */
module surf_cout_rx_tb;

    localparam int unsigned SEED         = 32'h70db3d9b;
    localparam int          APB_WAIT_MAX = 4;
    localparam int          POLL_MAX     = 100;

    logic                    sysclk_i    = 1'b0;
    logic                    cout_i      = 1'b0;
    logic                    dout_i      = 1'b0;
    logic                    cout_phase  = 1'b0;
    logic                    iserdes_rst_i;
    logic                    dout_sync_i;
    logic                    psel_i;
    logic                    penable_i;
    logic                    pwrite_i;
    surf_apb_pkg::apb_addr_t paddr_i;
    surf_apb_pkg::apb_data_t pwdata_i;
    surf_apb_pkg::apb_data_t prdata_o;
    logic                    pready_o;
    logic                    pslverr_o;

    // reference model, lane 0 is cout and lane 1 is dout
    logic [surf_phy_pkg::MAX_TAP:0] m_hist [2] = '{default: '0};
    surf_phy_pkg::tap_t             m_tap [2];
    surf_phy_pkg::tap_t             m_tap_reg;
    surf_phy_pkg::dout_word_t       m_dsr;
    surf_phy_pkg::cout_nib_t        m_csr;
    logic [11:0]                    m_pend_word;
    logic [11:0]                    m_q [$];
    logic                           m_hold;
    logic                           m_skip;
    logic                           m_pend;
    logic                           m_ovf;
    int                             m_cnt;

    surf_cout_rx surf_cout_rx_i (
        .sysclk_i     (sysclk_i),
        .iserdes_rst_i(iserdes_rst_i),
        .dout_sync_i  (dout_sync_i),
        .cout_i       (cout_i),
        .dout_i       (dout_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o)
    );

    always #5 sysclk_i = ~sysclk_i;

    // random serial bits, cout holds each bit for two cycles
    always @(posedge sysclk_i) begin : serial_drive
        logic [31:0] r;
        #1;
        r      = $urandom;
        dout_i = r[0];
        if (cout_phase) begin
            cout_i = r[1];
        end
        cout_phase = !cout_phase;
    end

    always @(posedge sysclk_i) begin : ref_model
        logic       acc;
        logic       ctrl_wr;
        logic       slip_d;
        logic       slip_c;
        logic       was_full;
        logic       done;
        logic [1:0] dly;
        acc     = psel_i && penable_i;
        ctrl_wr = acc && pwrite_i && paddr_i == surf_apb_pkg::REG_CTRL;
        slip_d  = ctrl_wr && pwdata_i[surf_apb_pkg::CTRL_SLIP_DOUT];
        slip_c  = ctrl_wr && pwdata_i[surf_apb_pkg::CTRL_SLIP_COUT];
        // a lane bit reaches the assembler tap+1 cycles after it was driven
        for (int l = 0; l < 2; l++) begin
            dly[l] = m_hist[l][m_tap[l]];
        end
        m_hist[0] = {m_hist[0][surf_phy_pkg::MAX_TAP-1:0], cout_i};
        m_hist[1] = {m_hist[1][surf_phy_pkg::MAX_TAP-1:0], dout_i};
        if (iserdes_rst_i) begin
            m_hold    = 1'b1;
            m_tap[0]  = '0;
            m_tap[1]  = '0;
            m_tap_reg = '0;
            m_cnt     = 0;
            m_dsr     = '0;
            m_csr     = '0;
            m_skip    = 1'b0;
            m_pend    = 1'b0;
            m_ovf     = 1'b0;
            m_q.delete();
        end else begin
            // fifo sees the word completed one cycle earlier
            was_full = (m_q.size() == surf_phy_pkg::FIFO_DEPTH);
            if (acc && !pwrite_i && paddr_i == surf_apb_pkg::REG_DATA && m_q.size() != 0) begin
                void'(m_q.pop_front());
            end
            if (m_pend && !was_full) begin
                m_q.push_back(m_pend_word);
            end
            if (m_pend && was_full) begin
                m_ovf = 1'b1;
            end else if (acc && pwrite_i && paddr_i == surf_apb_pkg::REG_STATUS && pwdata_i[8]) begin
                m_ovf = 1'b0;
            end
            if (ctrl_wr && pwdata_i[surf_apb_pkg::CTRL_LOAD_COUT]) begin
                m_tap[0] = m_tap_reg;
            end
            if (ctrl_wr && pwdata_i[surf_apb_pkg::CTRL_LOAD_DOUT]) begin
                m_tap[1] = m_tap_reg;
            end
            if (acc && pwrite_i && paddr_i == surf_apb_pkg::REG_TAP) begin
                m_tap_reg = pwdata_i[4:0];
            end
            if (m_hold) begin
                m_cnt  = 0;
                m_dsr  = '0;
                m_csr  = '0;
                m_skip = 1'b0;
                m_pend = 1'b0;
                m_hold = !dout_sync_i;
            end else begin
                done  = 1'b0;
                m_dsr = {m_dsr[surf_phy_pkg::DOUT_BITS-2:0], dly[1]};
                if (slip_d) begin
                    // counter stalls, a cout slip waits for the next shift slot
                    m_skip = m_skip || slip_c;
                end else if (m_cnt % 2 == 1) begin
                    if (!(m_skip || slip_c)) begin
                        m_csr = {m_csr[surf_phy_pkg::COUT_BITS-2:0], dly[0]};
                    end
                    m_skip = 1'b0;
                    done   = (m_cnt == surf_phy_pkg::DOUT_BITS - 1);
                    m_cnt  = (m_cnt + 1) % surf_phy_pkg::DOUT_BITS;
                end else begin
                    m_skip = m_skip || slip_c;
                    m_cnt  = m_cnt + 1;
                end
                m_pend = done;
                if (done) begin
                    m_pend_word = {m_csr, m_dsr};
                end
            end
        end
    end

    function automatic surf_apb_pkg::apb_data_t expected_rdata(surf_apb_pkg::apb_addr_t addr);
        surf_apb_pkg::apb_data_t d;
        d = '0;
        case (addr)
            surf_apb_pkg::REG_TAP: begin
                d[4:0] = m_tap_reg;
            end
            surf_apb_pkg::REG_TAP_CUR: begin
                d[4:0]  = m_tap[0];
                d[12:8] = m_tap[1];
            end
            surf_apb_pkg::REG_STATUS: begin
                d[3:0] = surf_phy_pkg::fill_t'(m_q.size());
                d[8]   = m_ovf;
            end
            surf_apb_pkg::REG_DATA: begin
                if (m_q.size() != 0) begin
                    d[11:0] = m_q[0];
                    d[31]   = 1'b1;
                end
            end
            default: begin
            end
        endcase
        return d;
    endfunction

    // read only registers refuse writes, holes refuse everything
    function automatic logic expected_err(logic wr, surf_apb_pkg::apb_addr_t addr);
        case (addr)
            surf_apb_pkg::REG_CTRL, surf_apb_pkg::REG_TAP, surf_apb_pkg::REG_STATUS: begin
                return 1'b0;
            end
            surf_apb_pkg::REG_TAP_CUR, surf_apb_pkg::REG_DATA: begin
                return wr;
            end
            default: begin
                return 1'b1;
            end
        endcase
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERR at %0t: %s got %0h, expected %0h",
                                        $time, what, got, exp));
        end
    endtask

    // called 1 unit after a rising edge, returns 1 unit after the access edge
    task automatic apb_access(input logic wr, input surf_apb_pkg::apb_addr_t addr,
                              input surf_apb_pkg::apb_data_t wdata,
                              output surf_apb_pkg::apb_data_t rdata, output logic err);
        int waits;
        psel_i   = 1'b1;
        pwrite_i = wr;
        paddr_i  = addr;
        pwdata_i = wdata;
        @(posedge sysclk_i);
        #1;
        penable_i = 1'b1;
        // mid access phase the model still holds the state before the edge
        @(negedge sysclk_i);
        waits = 0;
        while (!pready_o && waits < APB_WAIT_MAX) begin
            waits++;
            @(negedge sysclk_i);
        end
        if (!pready_o) begin
            stop_with_failure("APB access timed out without pready");
        end
        rdata = prdata_o;
        err   = pslverr_o;
        check_value(32'(err), 32'(expected_err(wr, addr)), "pslverr");
        if (!wr) begin
            check_value(rdata, expected_rdata(addr), "read data");
        end
        @(posedge sysclk_i);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic write_reg(input surf_apb_pkg::apb_addr_t addr, input surf_apb_pkg::apb_data_t data);
        surf_apb_pkg::apb_data_t rdata;
        logic err;
        apb_access(1'b1, addr, data, rdata, err);
    endtask

    task automatic read_reg(input surf_apb_pkg::apb_addr_t addr, output surf_apb_pkg::apb_data_t data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
    endtask

    task automatic wait_fill(input int target);
        surf_apb_pkg::apb_data_t rdata;
        int polls;
        polls = 0;
        read_reg(surf_apb_pkg::REG_STATUS, rdata);
        while (int'(rdata[3:0]) < target && polls < POLL_MAX) begin
            polls++;
            read_reg(surf_apb_pkg::REG_STATUS, rdata);
        end
        if (int'(rdata[3:0]) < target) begin
            stop_with_failure($sformatf("timed out waiting for fifo fill %0d", target));
        end
    endtask

    task automatic wait_overflow();
        surf_apb_pkg::apb_data_t rdata;
        int polls;
        polls = 0;
        read_reg(surf_apb_pkg::REG_STATUS, rdata);
        while (!rdata[8] && polls < POLL_MAX) begin
            polls++;
            read_reg(surf_apb_pkg::REG_STATUS, rdata);
        end
        if (!rdata[8]) begin
            stop_with_failure("timed out waiting for the overflow flag");
        end
        check_value(32'(rdata[3:0]), surf_phy_pkg::FIFO_DEPTH, "fill at overflow");
    endtask

    task automatic drain_fifo();
        surf_apb_pkg::apb_data_t rdata;
        int reads;
        reads = 0;
        read_reg(surf_apb_pkg::REG_DATA, rdata);
        while (rdata[31] && reads < POLL_MAX) begin
            reads++;
            read_reg(surf_apb_pkg::REG_DATA, rdata);
        end
        if (rdata[31]) begin
            stop_with_failure("fifo never ran empty while draining");
        end
    endtask

    task automatic read_words(input int n);
        surf_apb_pkg::apb_data_t rdata;
        repeat (n) begin
            read_reg(surf_apb_pkg::REG_DATA, rdata);
            check_value(32'(rdata[31]), 1, "word valid");
        end
    endtask

    initial begin : test_seq
        surf_apb_pkg::apb_data_t rdata;
        surf_phy_pkg::tap_t      c_tap;
        surf_phy_pkg::tap_t      d_tap;
        logic                    err;
        int                      n_slip;
        void'($urandom(SEED));
        iserdes_rst_i = 1'b1;
        dout_sync_i   = 1'b0;
        psel_i        = 1'b0;
        penable_i     = 1'b0;
        pwrite_i      = 1'b0;
        paddr_i       = '0;
        pwdata_i      = '0;
        repeat (10) @(posedge sysclk_i);
        #1;
        iserdes_rst_i = 1'b0;

        // nothing reaches the fifo until dout_sync_i
        repeat (5) begin
            repeat (8) @(posedge sysclk_i);
            #1;
            read_reg(surf_apb_pkg::REG_STATUS, rdata);
            check_value(32'(rdata[3:0]), 0, "fill while held");
        end
        dout_sync_i = 1'b1;
        @(posedge sysclk_i);
        #1;
        dout_sync_i = 1'b0;
        wait_fill(3);
        read_words(3);

        c_tap = surf_phy_pkg::tap_t'($urandom_range(31, 1));
        d_tap = surf_phy_pkg::tap_t'($urandom_range(31, 1));
        write_reg(surf_apb_pkg::REG_TAP, 32'(c_tap));
        write_reg(surf_apb_pkg::REG_CTRL, 32'(1) << surf_apb_pkg::CTRL_LOAD_COUT);
        write_reg(surf_apb_pkg::REG_TAP, 32'(d_tap));
        write_reg(surf_apb_pkg::REG_CTRL, 32'(1) << surf_apb_pkg::CTRL_LOAD_DOUT);
        read_reg(surf_apb_pkg::REG_TAP_CUR, rdata);
        check_value(32'(rdata[4:0]), 32'(c_tap), "cout tap");
        check_value(32'(rdata[12:8]), 32'(d_tap), "dout tap");
        drain_fifo();
        wait_fill(4);
        read_words(4);

        // one slip of each kind, then a random mix
        write_reg(surf_apb_pkg::REG_CTRL, 32'(1) << surf_apb_pkg::CTRL_SLIP_DOUT);
        write_reg(surf_apb_pkg::REG_CTRL, 32'(1) << surf_apb_pkg::CTRL_SLIP_COUT);
        n_slip = int'($urandom_range(6, 1));
        repeat (n_slip) begin
            write_reg(surf_apb_pkg::REG_CTRL, $urandom & 32'hC);
        end
        drain_fifo();
        wait_fill(4);
        read_words(4);

        drain_fifo();
        wait_overflow();
        read_words(surf_phy_pkg::FIFO_DEPTH);
        write_reg(surf_apb_pkg::REG_STATUS, 32'h100);
        read_reg(surf_apb_pkg::REG_STATUS, rdata);
        check_value(32'(rdata[8]), 0, "overflow after clear");

        apb_access(1'b0, 5'h14, '0, rdata, err);
        check_value(32'(err), 1, "pslverr on unmapped read");
        apb_access(1'b1, 5'h14, 32'h1, rdata, err);
        check_value(32'(err), 1, "pslverr on unmapped write");
        apb_access(1'b1, surf_apb_pkg::REG_DATA, 32'h5A, rdata, err);
        check_value(32'(err), 1, "pslverr on data write");

        // reset without sync keeps the fifo empty
        iserdes_rst_i = 1'b1;
        repeat (3) @(posedge sysclk_i);
        #1;
        iserdes_rst_i = 1'b0;
        repeat (16) @(posedge sysclk_i);
        #1;
        read_reg(surf_apb_pkg::REG_DATA, rdata);
        check_value(32'(rdata[31]), 0, "valid on empty read");

        $display("Testbench passed");
        $finish;
    end

endmodule

/* all.f */
logic/surf_phy_pkg.sv
logic/surf_apb_pkg.sv
logic/rx_ifs.sv
logic/lane_deserializer.sv
logic/word_fifo.sv
logic/phy_ctrl_apb.sv
logic/surf_cout_rx.sv
sim/surf_cout_rx_sva.sv
sim/surf_cout_rx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, the log decides pass or fail

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f all.f --top-module surf_cout_rx_tb \
    -Mdir obj_dir -o surf_cout_rx_tb_sim \
    && ./obj_dir/surf_cout_rx_tb_sim 2>&1 | tee sim.log \
    || { echo "build or run failed"; exit 1; }

grep -q "^Testbench passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
